//--- filelist.f
rtl/axi_pkg.sv
rtl/rd_cfg_pkg.sv
rtl/rd_job_control.sv
rtl/ar_issuer.sv
rtl/r_tracker.sv
rtl/beat_fifo.sv
rtl/axi_read_master.sv
verif/axi_mem_model.sv
verif/tb_axi_read_master.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_axi_read_master -Mdir obj_dir -f filelist.f

./obj_dir/Vtb_axi_read_master 2>&1 | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

//--- verif/tb_axi_read_master.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axi_read_master
  import axi_pkg::*, rd_cfg_pkg::*;
();

  localparam int num_jobs          = 6;
  localparam int beats_per_burst   = 256;
  localparam int outstanding_limit = 4;
  // Stream stall in the last job long enough to use up every credit
  localparam int hold_cycles       = 1500;

  typedef struct packed {
    addr_t             addr;
    logic [size_w-1:0] size;
    addr_t             base;
    logic [31:0]       beats;
  } job_entry_t;

  job_entry_t jobs [num_jobs];

  logic              aclk = 1'b0;
  logic              areset;
  logic              start;
  addr_t             addr_offset;
  logic [size_w-1:0] xfer_size;
  logic              busy;
  logic              done;
  logic              arvalid;
  logic              arready;
  ar_req_t           ar;
  logic              rvalid;
  logic              rready;
  r_beat_t           r;
  logic              tvalid;
  logic              tready;
  axis_beat_t        t;

  // Running job as set by the main sequence
  addr_t cur_base;
  int    cur_beats;
  int    beat_base;
  int    burst_base;
  logic  hold_low;
  logic  table_ready;

  // Totals kept by the monitor
  int stream_total;
  int r_total;
  int ar_total;
  int drained_total;
  int done_total;
  int peak_outstanding;

  axi_read_master axi_read_master_i (
    .aclk        (aclk),
    .areset      (areset),
    .start       (start),
    .addr_offset (addr_offset),
    .xfer_size   (xfer_size),
    .busy        (busy),
    .done        (done),
    .arvalid     (arvalid),
    .arready     (arready),
    .ar          (ar),
    .rvalid      (rvalid),
    .rready      (rready),
    .r           (r),
    .tvalid      (tvalid),
    .tready      (tready),
    .t           (t)
  );

  axi_mem_model mem_model_i (
    .aclk    (aclk),
    .areset  (areset),
    .arvalid (arvalid),
    .arready (arready),
    .ar      (ar),
    .rvalid  (rvalid),
    .rready  (rready),
    .r       (r)
  );

  always #4 aclk = ~aclk;

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED %s: got 0x%08h expected 0x%08h", sig, got, exp);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("Check failed: %s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  // Full bursts, then whatever remains in the last one
  function automatic int expected_arlen(input int beats, input int k);
    int nb;
    nb = (beats + beats_per_burst - 1) / beats_per_burst;
    if (k < nb - 1) begin
      return beats_per_burst - 1;
    end
    return beats - beats_per_burst * (nb - 1) - 1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stream ready with random gaps and a long stall phase
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    tready = 1'b0;
    forever begin
      @(posedge aclk);
      #1;
      tready = !hold_low && (($urandom % 2) == 0);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Monitor on AR, R, stream and done
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge aclk) begin : monitor
    int   idx;
    int   k;
    logic exp_last;
    if (!areset) begin
      if (arvalid && arready) begin
        k = ar_total - burst_base;
        assert (k < (cur_beats + beats_per_burst - 1) / beats_per_burst)
          else report_failure("address burst issued past the end of the job");
        assert (ar.araddr == cur_base + 32'(k * beats_per_burst * 4))
          else report_mismatch("araddr", ar.araddr, cur_base + 32'(k * beats_per_burst * 4));
        assert (32'(ar.arlen) == expected_arlen(cur_beats, k))
          else report_mismatch("arlen", 32'(ar.arlen), expected_arlen(cur_beats, k));
        ar_total++;
      end
      // R is never stalled once out of reset
      assert (rready) else report_mismatch("rready", 32'(rready), 32'd1);
      if (rvalid && rready) begin
        assert (busy) else report_failure("read beat arrived while busy was low");
        r_total++;
      end
      if (tvalid && tready) begin
        idx      = stream_total - beat_base;
        exp_last = ((idx % beats_per_burst) == beats_per_burst - 1) || (idx == cur_beats - 1);
        assert (idx < cur_beats) else report_failure("stream carried more beats than the job");
        assert (t.tdata == cur_base + 32'(4 * idx))
          else report_mismatch("tdata", t.tdata, cur_base + 32'(4 * idx));
        assert (t.tlast == exp_last)
          else report_mismatch("tlast", 32'(t.tlast), 32'(exp_last));
        if (t.tlast) begin
          drained_total++;
        end
        stream_total++;
      end
      // Bursts issued but not yet drained on the stream
      assert (ar_total - drained_total <= outstanding_limit)
        else report_mismatch("outstanding", ar_total - drained_total, outstanding_limit);
      if (ar_total - drained_total > peak_outstanding) begin
        peak_outstanding = ar_total - drained_total;
      end
      if (done) begin
        assert (r_total - beat_base == cur_beats)
          else report_mismatch("read beats at done", r_total - beat_base, cur_beats);
        assert (!busy) else report_failure("busy still high in the done cycle");
        done_total++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin : watchdog
    int limit_cycles;
    wait (table_ready);
    limit_cycles = 0;
    for (int j = 0; j < num_jobs; j++) begin
      limit_cycles += 200 + 4 * int'(jobs[j].beats);
    end
    repeat (limit_cycles) @(posedge aclk);
    $display("Timeout: run did not finish within %0d cycles", limit_cycles);
    $display("ERRORS FOUND");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    int wait_cycles;
    void'($urandom(32'hf4120682));
    areset      = 1'b1;
    start       = 1'b0;
    addr_offset = '0;
    xfer_size   = '0;
    hold_low    = 1'b0;
    cur_base    = '0;
    cur_beats   = 0;
    beat_base   = 0;
    burst_base  = 0;
    // Address, size in bytes, aligned base, beats
    jobs[0] = '{32'h0000_1000, 16'd4,     32'h0000_1000, 32'd1};
    // Unaligned start
    jobs[1] = '{32'h0000_2234, 16'd100,   32'h0000_2000, 32'd25};
    jobs[2] = '{32'h0000_0000, 16'd1024,  32'h0000_0000, 32'd256};
    // One byte past a full burst
    jobs[3] = '{32'h0000_3000, 16'd1025,  32'h0000_3000, 32'd257};
    jobs[4] = '{32'h0001_0000, 16'd5000,  32'h0001_0000, 32'd1250};
    // Sixteen bursts
    jobs[5] = '{32'h0002_0000, 16'd16384, 32'h0002_0000, 32'd4096};
    table_ready = 1'b1;

    repeat (4) @(posedge aclk);
    #1;
    areset = 1'b0;
    @(posedge aclk);
    assert (!arvalid) else report_mismatch("arvalid after reset", 32'(arvalid), 32'd0);
    assert (!tvalid) else report_mismatch("tvalid after reset", 32'(tvalid), 32'd0);
    assert (!busy) else report_mismatch("busy after reset", 32'(busy), 32'd0);
    assert (!done) else report_mismatch("done after reset", 32'(done), 32'd0);

    for (int j = 0; j < num_jobs; j++) begin
      @(posedge aclk);
      hold_low = (j == num_jobs - 1);
      #1;
      if (j > 0) begin
        beat_base  += cur_beats;
        burst_base += (cur_beats + beats_per_burst - 1) / beats_per_burst;
      end
      cur_base    = jobs[j].base;
      cur_beats   = int'(jobs[j].beats);
      start       = 1'b1;
      addr_offset = jobs[j].addr;
      xfer_size   = jobs[j].size;
      @(posedge aclk);
      #1;
      start = 1'b0;
      // busy rises with launch two cycles after start
      repeat (2) @(posedge aclk);
      assert (busy) else report_failure("busy did not rise after start");
      wait_cycles = 0;
      while (!done) begin
        assert (busy) else report_failure("busy dropped before done");
        if (hold_low && wait_cycles >= hold_cycles) begin
          hold_low = 1'b0;
        end
        @(posedge aclk);
        wait_cycles++;
      end
      @(negedge aclk);
      // FIFO may still hold beats after done
      wait (stream_total - beat_base >= cur_beats);
      assert (done_total == j + 1) else report_mismatch("done pulses", done_total, j + 1);
    end

    repeat (20) @(posedge aclk);
    @(negedge aclk);
    assert (stream_total == beat_base + cur_beats)
      else report_mismatch("stream beats", stream_total, beat_base + cur_beats);
    assert (done_total == num_jobs) else report_mismatch("done pulses", done_total, num_jobs);
    assert (peak_outstanding == outstanding_limit)
      else report_mismatch("peak outstanding", peak_outstanding, outstanding_limit);
    $display("NO ERRORS");
    $finish;
  end

endmodule : tb_axi_read_master

`default_nettype wire

//--- verif/axi_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module axi_mem_model
  import axi_pkg::*;
(
  input  logic    aclk,
  input  logic    areset,
  // Read address
  input  logic    arvalid,
  output logic    arready,
  input  ar_req_t ar,
  // Read data
  output logic    rvalid,
  input  logic    rready,
  output r_beat_t r
);

  // Accepted bursts, oldest first
  ar_req_t          bursts [$];
  logic [len_w-1:0] beat_idx;

  // Data word of a beat is its own byte address
  function automatic r_beat_t beat_of(input ar_req_t req, input logic [len_w-1:0] idx);
    r_beat_t beat;
    beat.rdata = req.araddr + (data_t'(idx) << 2);
    beat.rlast = (idx == req.arlen);
    return beat;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Slave behavior, one pass per clock
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    arready  = 1'b0;
    rvalid   = 1'b0;
    r        = '0;
    beat_idx = '0;
    forever begin
      @(posedge aclk);
      if (areset) begin
        bursts.delete();
        beat_idx = '0;
      end else begin
        // Handshakes of the cycle that just closed
        if (arvalid && arready) begin
          bursts.push_back(ar);
        end
        if (rvalid && rready) begin
          if (r.rlast) begin
            bursts.delete(0);
            beat_idx = '0;
          end else begin
            beat_idx++;
          end
        end
      end
      #1;
      arready = !areset && (($urandom % 2) == 0);
      // Valid only drops once the beat is taken
      if (!rvalid || rready) begin
        rvalid = !areset && (bursts.size() > 0) && (($urandom % 4) != 0);
        if (rvalid) begin
          r = beat_of(bursts[0], beat_idx);
        end
      end
    end
  end

endmodule : axi_mem_model

`default_nettype wire

//--- rtl/axi_read_master.sv
`timescale 1ns/1ns
`default_nettype none

module axi_read_master
  import axi_pkg::*, rd_cfg_pkg::*;
(
  input  logic              aclk,
  input  logic              areset,
  // Job control
  input  logic              start,
  input  addr_t             addr_offset,
  input  logic [size_w-1:0] xfer_size,
  output logic              busy,
  output logic              done,
  // AXI read address
  output logic              arvalid,
  input  logic              arready,
  output ar_req_t           ar,
  // AXI read data
  input  logic              rvalid,
  output logic              rready,
  input  r_beat_t           r,
  // AXI4-Stream out
  output logic              tvalid,
  input  logic              tready,
  output axis_beat_t        t
);

  job_t job;
  logic launch;
  logic ar_done;
  logic burst_drained;
  logic last_burst_in;

  // FIFO holds every outstanding burst
  assign rready = 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////////////////////

  rd_job_control rd_job_control_i (
    .aclk          (aclk),
    .areset        (areset),
    .start         (start),
    .addr_offset   (addr_offset),
    .xfer_size     (xfer_size),
    .ar_done       (ar_done),
    .last_burst_in (last_burst_in),
    .job           (job),
    .launch        (launch),
    .busy          (busy),
    .done          (done)
  );

  ar_issuer ar_issuer_i (
    .aclk          (aclk),
    .areset        (areset),
    .job           (job),
    .launch        (launch),
    .burst_drained (burst_drained),
    .arvalid       (arvalid),
    .arready       (arready),
    .ar            (ar),
    .ar_done       (ar_done)
  );

  // Runs beside the issuer on the R channel
  r_tracker r_tracker_i (
    .aclk          (aclk),
    .areset        (areset),
    .job           (job),
    .launch        (launch),
    .rvalid        (rvalid),
    .r             (r),
    .last_burst_in (last_burst_in)
  );

  beat_fifo beat_fifo_i (
    .aclk          (aclk),
    .areset        (areset),
    .rvalid        (rvalid),
    .r             (r),
    .tvalid        (tvalid),
    .tready        (tready),
    .t             (t),
    .burst_drained (burst_drained)
  );

endmodule : axi_read_master

`default_nettype wire

//--- rtl/beat_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module beat_fifo
  import axi_pkg::*, rd_cfg_pkg::*;
(
  input  logic       aclk,
  input  logic       areset,
  input  logic       rvalid,
  input  r_beat_t    r,
  output logic       tvalid,
  input  logic       tready,
  output axis_beat_t t,
  output logic       burst_drained
);

  r_beat_t          mem [fifo_depth];
  logic [fifo_aw:0] wr_ptr;
  logic [fifo_aw:0] rd_ptr;
  logic             mem_empty;
  logic             mem_full;
  logic             pop;
  logic             load;
  logic             bypass;
  logic             mem_wr;
  logic             mem_rd;
  r_beat_t          head;

  ////////////////////////////////////////////////////////////////////////////
  // Flags and steering
  ////////////////////////////////////////////////////////////////////////////

  // Extra pointer bit tells full from empty
  assign mem_empty = (wr_ptr == rd_ptr);
  assign mem_full  = (wr_ptr[fifo_aw] != rd_ptr[fifo_aw]) &&
                     (wr_ptr[fifo_aw-1:0] == rd_ptr[fifo_aw-1:0]);

  assign pop    = tvalid && tready;
  // Output stage free this cycle
  assign load   = !tvalid || pop;
  // Empty memory, so a new beat skips straight to the output
  assign bypass = load && mem_empty;
  assign mem_wr = rvalid && !bypass;
  assign mem_rd = load && !mem_empty;

  // Oldest beat, memory first to keep order
  assign head = mem_empty ? r : mem[rd_ptr[fifo_aw-1:0]];

  assign burst_drained = pop && t.tlast;

  ////////////////////////////////////////////////////////////////////////////
  // Storage and output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (mem_wr) begin
      mem[wr_ptr[fifo_aw-1:0]] <= r;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      tvalid <= 1'b0;
    end else begin
      if (mem_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (mem_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (load) begin
        tvalid <= rvalid || !mem_empty;
      end
    end
  end

  // Beat written in one cycle is visible on the stream in the next
  always_ff @(posedge aclk) begin
    if (load && (rvalid || !mem_empty)) begin
      t.tdata <= head.rdata;
      t.tlast <= head.rlast;
    end
  end

  // Credit limit upstream keeps the memory from overflowing
  no_overflow_a : assert property (@(posedge aclk) disable iff (areset)
    mem_wr |-> !mem_full);

endmodule : beat_fifo

`default_nettype wire

//--- rtl/r_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module r_tracker
  import axi_pkg::*, rd_cfg_pkg::*;
(
  input  logic    aclk,
  input  logic    areset,
  input  job_t    job,
  input  logic    launch,
  input  logic    rvalid,
  input  r_beat_t r,
  output logic    last_burst_in
);

  burst_cnt_t bursts_left;
  logic       tracking;
  logic       rlast_xfer;

  // rready is tied high, so valid alone is a transfer
  assign rlast_xfer    = rvalid && r.rlast;
  assign last_burst_in = rlast_xfer && tracking && (bursts_left == '0);

  always_ff @(posedge aclk) begin
    if (areset) begin
      tracking <= 1'b0;
    end else if (launch) begin
      tracking <= 1'b1;
    end else if (last_burst_in) begin
      tracking <= 1'b0;
    end
  end

  // Bursts still to complete after the current one
  always_ff @(posedge aclk) begin
    if (launch) begin
      bursts_left <= job.num_bursts;
    end else if (rlast_xfer && tracking && bursts_left != '0) begin
      bursts_left <= bursts_left - 1'b1;
    end
  end

  // Slave returns data only for addresses of the running job
  no_stray_rlast_a : assert property (@(posedge aclk) disable iff (areset)
    rlast_xfer |-> tracking);

endmodule : r_tracker

`default_nettype wire

//--- rtl/ar_issuer.sv
`timescale 1ns/1ns
`default_nettype none

module ar_issuer
  import axi_pkg::*, rd_cfg_pkg::*;
(
  input  logic    aclk,
  input  logic    areset,
  input  job_t    job,
  input  logic    launch,
  input  logic    burst_drained,
  output logic    arvalid,
  input  logic    arready,
  output ar_req_t ar,
  output logic    ar_done
);

  addr_t               addr_r;
  burst_cnt_t          bursts_left;
  logic                issuing;
  logic [credit_w-1:0] credits;
  logic                arxfer;
  logic                final_burst;
  logic                raise;

  assign arxfer      = arvalid && arready;
  // Countdown at zero means the current address is the last one
  assign final_burst = (bursts_left == '0);
  assign ar_done     = arxfer && final_burst;

  // Raise on launch or between bursts, only with a free credit
  assign raise = (launch || issuing) && !arvalid && (credits != '0);

  ////////////////////////////////////////////////////////////////////////////
  // AR handshake
  ////////////////////////////////////////////////////////////////////////////

  // Valid drops after accept, so at least one idle cycle per burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid <= 1'b0;
    end else if (raise) begin
      arvalid <= 1'b1;
    end else if (arready) begin
      arvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      issuing <= 1'b0;
    end else if (launch) begin
      issuing <= 1'b1;
    end else if (ar_done) begin
      issuing <= 1'b0;
    end
  end

  // Address and countdown move only on accept
  always_ff @(posedge aclk) begin
    if (launch) begin
      addr_r      <= job.base;
      bursts_left <= job.num_bursts;
    end else if (arxfer) begin
      addr_r <= addr_r + addr_t'(burst_bytes);
      if (!final_burst) begin
        bursts_left <= bursts_left - 1'b1;
      end
    end
  end

  always_comb begin
    ar.araddr = addr_r;
    ar.arlen  = final_burst ? job.final_len : len_w'(burst_beats - 1);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding credits
  ////////////////////////////////////////////////////////////////////////////

  // One credit per burst, returned when the stream drains it
  always_ff @(posedge aclk) begin
    if (areset) begin
      credits <= credit_w'(max_outstanding);
    end else if (arxfer && !burst_drained) begin
      credits <= credits - 1'b1;
    end else if (burst_drained && !arxfer) begin
      credits <= credits + 1'b1;
    end
  end

  ar_stable_a : assert property (@(posedge aclk) disable iff (areset)
    arvalid && !arready |=> arvalid && $stable(ar));

  // Drained bursts never outnumber issued ones
  credit_bound_a : assert property (@(posedge aclk) disable iff (areset)
    credits <= credit_w'(max_outstanding));

endmodule : ar_issuer

`default_nettype wire

//--- rtl/rd_job_control.sv
`timescale 1ns/1ns
`default_nettype none

module rd_job_control
  import axi_pkg::*, rd_cfg_pkg::*;
(
  input  logic              aclk,
  input  logic              areset,
  input  logic              start,
  input  addr_t             addr_offset,
  input  logic [size_w-1:0] xfer_size,
  input  logic              ar_done,
  input  logic              last_burst_in,
  output job_t              job,
  output logic              launch,
  output logic              busy,
  output logic              done
);

  addr_t                  base_r;
  logic [total_len_w-1:0] total_len_r;
  logic                   start_d1;
  logic                   accept;
  logic                   ar_active;

  // Ignore starts while a job is running or still in the pipeline
  assign accept = start && !busy && !start_d1;

  ////////////////////////////////////////////////////////////////////////////
  // Request capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (accept) begin
      // Round up to whole words, store as count minus one
      total_len_r <= (xfer_size[log_word_bytes-1:0] != '0)
                     ? xfer_size[size_w-1:log_word_bytes]
                     : xfer_size[size_w-1:log_word_bytes] - 1'b1;
      // Force 4 kB alignment
      base_r      <= addr_offset & ~addr_t'(boundary_bytes - 1);
    end
  end

  // Upper bits count full bursts, low bits give the last arlen
  always_comb begin
    job.base       = base_r;
    job.num_bursts = total_len_r[log_burst +: burst_cnt_w];
    job.final_len  = total_len_r[log_burst-1:0];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Launch, busy and done
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1  <= 1'b0;
      launch    <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      ar_active <= 1'b0;
    end else begin
      start_d1 <= accept;
      // Two cycles after start, job fields settled by now
      launch   <= start_d1;
      // Done only once the address phase has closed
      done     <= last_burst_in && !ar_active;
      if (start_d1) begin
        busy <= 1'b1;
      end else if (last_burst_in && !ar_active) begin
        busy <= 1'b0;
      end
      if (start_d1) begin
        ar_active <= 1'b1;
      end else if (ar_done) begin
        ar_active <= 1'b0;
      end
    end
  end

  // Issuer finishes only a job that was launched
  ar_done_in_job_a : assert property (@(posedge aclk) disable iff (areset)
    ar_done |-> ar_active);

endmodule : rd_job_control

`default_nettype wire

//--- rtl/rd_cfg_pkg.sv
`default_nettype none

package rd_cfg_pkg;

  import axi_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Engine configuration
  ////////////////////////////////////////////////////////////////////////////

  // Width of the byte-size request
  localparam int size_w          = 16;
  localparam int word_bytes      = data_w / 8;
  localparam int log_word_bytes  = $clog2(word_bytes);

  // Longest burst allowed by both the beat limit and the 4 kB rule
  localparam int burst_beats     = (boundary_bytes / word_bytes < max_burst_beats)
                                   ? boundary_bytes / word_bytes : max_burst_beats;
  localparam int log_burst       = $clog2(burst_beats);
  // Address step between consecutive bursts
  localparam int burst_bytes     = burst_beats * word_bytes;

  // Credit count, zero to max_outstanding inclusive
  localparam int max_outstanding = 4;
  localparam int credit_w        = $clog2(max_outstanding + 1);

  // FIFO holds every outstanding burst so R never stalls
  localparam int fifo_depth      = 2 ** $clog2(burst_beats * max_outstanding);
  localparam int fifo_aw         = $clog2(fifo_depth);

  // Word count minus one, then split into bursts
  localparam int total_len_w     = size_w - log_word_bytes;
  localparam int burst_cnt_w     = total_len_w - log_burst;

  typedef logic [burst_cnt_w-1:0] burst_cnt_t;

  // Burst plan of one job
  typedef struct packed {
    addr_t            base;
    // Full bursts before the last one
    burst_cnt_t       num_bursts;
    // arlen of the last burst
    logic [len_w-1:0] final_len;
  } job_t;

endpackage : rd_cfg_pkg

`default_nettype wire

//--- rtl/axi_pkg.sv
`default_nettype none

package axi_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths and protocol limits
  ////////////////////////////////////////////////////////////////////////////

  localparam int addr_w          = 32;
  localparam int data_w          = 32;
  // arlen carries the beat count minus one
  localparam int len_w           = 8;
  // AXI4 INCR burst limits
  localparam int max_burst_beats = 256;
  localparam int boundary_bytes  = 4096;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;

  ////////////////////////////////////////////////////////////////////////////
  // Channel payloads
  ////////////////////////////////////////////////////////////////////////////

  // Read address channel, only the fields this master drives
  typedef struct packed {
    addr_t            araddr;
    logic [len_w-1:0] arlen;
  } ar_req_t;

  // Read data channel beat, also the FIFO entry
  typedef struct packed {
    data_t rdata;
    logic  rlast;
  } r_beat_t;

  // AXI4-Stream payload
  typedef struct packed {
    data_t tdata;
    logic  tlast;
  } axis_beat_t;

endpackage : axi_pkg

`default_nettype wire
